/* hw/mbus_pkg.sv */
package mbus_pkg;

	// bus widths
	localparam int ADDR_WIDTH = 8;
	localparam int DATA_WIDTH = 32;

	// every node accepts frames sent here
	localparam logic [ADDR_WIDTH-1:0] BROADCAST_ADDR = '1;

	// low bits ahead of the sync bit, long enough to wake a sleeping node
	localparam int PREAMBLE_LEN = 4;

	// address plus data, shifted msb first
	localparam int FRAME_BITS = ADDR_WIDTH + DATA_WIDTH;

	// stages between a gated and a running bus controller
	typedef enum logic [1:0] {
		ST_ASLEEP,	// clock gated, held in reset, isolated
		ST_REL_CLK,	// clock running, still in reset
		ST_REL_RST,	// out of reset, outputs still isolated
		ST_AWAKE	// fully released
	} sleep_state_t;

endpackage

/* hw/mbus_sleep_ctrl.sv */
`timescale 1ns/1ns

module mbus_sleep_ctrl (
	input  logic clkin,
	input  logic rst_n,
	input  logic wake_det,
	input  logic req_int,
	input  logic tx_req,
	input  logic sleep_req,
	output logic bus_clk_en,
	output logic bus_rst,
	output logic iso
);
	import mbus_pkg::*;

	sleep_state_t state;
	logic going_down;	// set while stepping back towards asleep
	logic wake_any;

	// ring activity, an interrupt or a pending layer transmit
	assign wake_any = wake_det || req_int || tx_req;

	always_ff @(posedge clkin or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= ST_ASLEEP;
			going_down <= 1'b0;
		end
		else
		begin
			case (state)
				ST_ASLEEP:
				begin
					going_down <= 1'b0;
					if (wake_any)
						state <= ST_REL_CLK;
				end
				ST_REL_CLK:
					state <= going_down ? ST_ASLEEP : ST_REL_RST;
				ST_REL_RST:
					state <= going_down ? ST_REL_CLK : ST_AWAKE;
				ST_AWAKE:
				begin
					if (sleep_req)
					begin
						state <= ST_REL_RST;	// isolate first
						going_down <= 1'b1;
					end
				end
				default:
					state <= ST_ASLEEP;
			endcase
		end
	end

	assign bus_clk_en = (state != ST_ASLEEP);
	assign bus_rst = (state == ST_ASLEEP) || (state == ST_REL_CLK);
	assign iso = (state != ST_AWAKE);

	// the layer side must never see a controller that is being reset
	a_iso_covers_rst: assert property (@(posedge clkin) disable iff (!rst_n)
		bus_rst |-> iso);

endmodule

/* hw/mbus_wire_ctrl.sv */
`timescale 1ns/1ns

module mbus_wire_ctrl (
	input  logic clkin,
	input  logic rst_n,
	input  logic din,
	input  logic iso,
	input  logic tx_active,
	input  logic tx_bit,
	output logic dout,
	output logic wake_det
);

	logic din_q;	// ring sample for wake detection
	logic drive;

	// the controller owns the ring only once it is released
	assign drive = tx_active && !iso;

	always_ff @(posedge clkin or negedge rst_n)
	begin
		if (!rst_n)
		begin
			din_q <= 1'b1;	// idle ring is high
			dout <= 1'b1;
		end
		else
		begin
			din_q <= din;
			dout <= drive ? tx_bit : din;	// forward with one cycle of delay
		end
	end

	// any low bit on the ring starts a preamble
	assign wake_det = !din_q;

	// the bus controller is never transmitting behind isolation
	a_no_tx_while_iso: assert property (@(posedge clkin) disable iff (!rst_n)
		iso |-> !tx_active);

endmodule

/* hw/mbus_layer_if.sv */
`timescale 1ns/1ns

module mbus_layer_if (
	input  logic clkin,
	input  logic rst_n,
	input  logic iso,
	input  logic [mbus_pkg::ADDR_WIDTH-1:0] tx_addr,
	input  logic [mbus_pkg::DATA_WIDTH-1:0] tx_data,
	input  logic tx_req,
	output logic tx_ack,
	output logic [mbus_pkg::ADDR_WIDTH-1:0] rx_addr,
	output logic [mbus_pkg::DATA_WIDTH-1:0] rx_data,
	output logic rx_broadcast,
	output logic rx_req,
	input  logic rx_ack,
	output logic rx_fail,
	output logic tx_valid,
	input  logic tx_ready,
	input  logic tx_done,
	input  logic bus_rx_valid,
	input  logic [mbus_pkg::ADDR_WIDTH-1:0] bus_rx_addr,
	input  logic [mbus_pkg::DATA_WIDTH-1:0] bus_rx_data,
	input  logic bus_rx_broadcast,
	output logic rx_ready
);
	import mbus_pkg::*;

	logic tx_req_q;
	logic tx_pend;
	logic tx_ready_m, tx_done_m, rx_valid_m, rx_bcast_m;
	logic [ADDR_WIDTH-1:0] rx_addr_m;
	logic [DATA_WIDTH-1:0] rx_data_m;

	// bus side is clamped while the controller is gated
	assign tx_ready_m = tx_ready && !iso;
	assign tx_done_m = tx_done && !iso;
	assign rx_valid_m = bus_rx_valid && !iso;
	assign rx_bcast_m = bus_rx_broadcast && !iso;
	assign rx_addr_m = iso ? '0 : bus_rx_addr;
	assign rx_data_m = iso ? '0 : bus_rx_data;

	assign tx_valid = tx_pend && !iso;
	assign rx_ready = !rx_req && !rx_ack;	// previous handshake fully closed

	always_ff @(posedge clkin or negedge rst_n)
	begin
		if (!rst_n)
		begin
			tx_req_q <= 1'b0;
			tx_pend <= 1'b0;
			tx_ack <= 1'b0;
			rx_req <= 1'b0;
			rx_fail <= 1'b0;
		end
		else
		begin
			tx_req_q <= tx_req;
			if (tx_req && !tx_req_q && !tx_ack)
				tx_pend <= 1'b1;	// new request from the layer
			else if (tx_valid && tx_ready_m)
				tx_pend <= 1'b0;
			if (tx_done_m)
				tx_ack <= 1'b1;
			else if (!tx_req)
				tx_ack <= 1'b0;
			if (rx_valid_m && rx_ready)
				rx_req <= 1'b1;
			else if (rx_ack)
				rx_req <= 1'b0;
			if (rx_valid_m && !rx_ready)
				rx_fail <= 1'b1;	// frame dropped, layer still busy
			else if (rx_ack)
				rx_fail <= 1'b0;
		end
	end

	always_ff @(posedge clkin)
	begin
		if (rx_valid_m && rx_ready)
		begin
			rx_addr <= rx_addr_m;
			rx_data <= rx_data_m;
			rx_broadcast <= rx_bcast_m;
		end
	end

	// four-phase outputs only fall after their acknowledge
	a_rx_req_hold: assert property (@(posedge clkin) disable iff (!rst_n)
		rx_req && !rx_ack |=> rx_req);
	a_tx_ack_hold: assert property (@(posedge clkin) disable iff (!rst_n)
		tx_ack && tx_req |=> tx_ack);
	// layer keeps the payload steady until the controller has loaded it
	a_tx_payload_stable: assert property (@(posedge clkin) disable iff (!rst_n)
		tx_pend && !(tx_valid && tx_ready_m) |=> $stable({tx_addr, tx_data}));

endmodule

/* hw/mbus_bus_ctrl.sv */
`timescale 1ns/1ns

module mbus_bus_ctrl #(
	parameter logic [mbus_pkg::ADDR_WIDTH-1:0] ADDRESS = 8'h01,
	parameter logic [15:0] SLEEP_THRESHOLD = 16'd1024
) (
	input  logic clkin,
	input  logic rst_n,
	input  logic clk_en,
	input  logic bus_rst,
	input  logic din,
	input  logic tx_valid,
	input  logic [mbus_pkg::ADDR_WIDTH-1:0] tx_addr,
	input  logic [mbus_pkg::DATA_WIDTH-1:0] tx_data,
	output logic tx_ready,
	output logic tx_done,
	output logic tx_active,
	output logic tx_bit,
	output logic rx_valid,
	output logic [mbus_pkg::ADDR_WIDTH-1:0] rx_addr,
	output logic [mbus_pkg::DATA_WIDTH-1:0] rx_data,
	output logic rx_broadcast,
	input  logic rx_ready,
	output logic sleep_req
);
	import mbus_pkg::*;

	localparam int CNT_W = $clog2(FRAME_BITS);

	typedef enum logic [1:0] {TX_IDLE, TX_PRE, TX_SYNC, TX_DATA} tx_state_t;
	typedef enum logic [1:0] {RX_IDLE, RX_PRE, RX_DATA} rx_state_t;

	tx_state_t tx_state;
	rx_state_t rx_state;
	logic [CNT_W-1:0] tx_cnt, rx_cnt;
	logic [FRAME_BITS-1:0] tx_sh, rx_sh, rx_next;
	logic [ADDR_WIDTH-1:0] next_addr;
	logic tx_start, rx_last, addr_hit, idle;
	logic [15:0] idle_cnt;

	assign tx_ready = clk_en && (tx_state == TX_IDLE) && (rx_state == RX_IDLE);
	assign tx_start = tx_valid && tx_ready;
	assign tx_active = (tx_state != TX_IDLE);

	always_comb
	begin
		case (tx_state)
			TX_SYNC: tx_bit = 1'b1;
			TX_DATA: tx_bit = tx_sh[FRAME_BITS-1];
			default: tx_bit = 1'b0;	// preamble
		endcase
	end

	always_ff @(posedge clkin or negedge rst_n)
	begin
		if (!rst_n)
		begin
			tx_state <= TX_IDLE;
			tx_cnt <= '0;
			tx_done <= 1'b0;
		end
		else if (bus_rst)
		begin
			tx_state <= TX_IDLE;
			tx_cnt <= '0;
			tx_done <= 1'b0;
		end
		else if (clk_en)
		begin
			tx_done <= 1'b0;
			case (tx_state)
				TX_IDLE:
				begin
					if (tx_start)
					begin
						tx_state <= TX_PRE;
						tx_cnt <= CNT_W'(PREAMBLE_LEN - 1);
					end
				end
				TX_PRE:
				begin
					if (tx_cnt == '0)
						tx_state <= TX_SYNC;
					else
						tx_cnt <= tx_cnt - 1'b1;
				end
				TX_SYNC:
				begin
					tx_state <= TX_DATA;
					tx_cnt <= CNT_W'(FRAME_BITS - 1);
				end
				default:
				begin
					if (tx_cnt == '0)
					begin
						tx_state <= TX_IDLE;
						tx_done <= 1'b1;	// last payload bit just went out
					end
					else
						tx_cnt <= tx_cnt - 1'b1;
				end
			endcase
		end
	end

	always_ff @(posedge clkin)
	begin
		if (clk_en && !bus_rst)
		begin
			if (tx_start)
				tx_sh <= {tx_addr, tx_data};
			else if (tx_state == TX_DATA)
				tx_sh <= {tx_sh[FRAME_BITS-2:0], 1'b0};
			if (rx_state == RX_DATA)
				rx_sh <= rx_next;
		end
	end

	assign rx_next = {rx_sh[FRAME_BITS-2:0], din};
	assign next_addr = rx_next[FRAME_BITS-1 -: ADDR_WIDTH];
	assign addr_hit = (next_addr == ADDRESS) || (next_addr == BROADCAST_ADDR);
	assign rx_last = (rx_state == RX_DATA) && (rx_cnt == '0);

	always_ff @(posedge clkin or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rx_state <= RX_IDLE;
			rx_cnt <= '0;
			rx_valid <= 1'b0;
		end
		else if (bus_rst)
		begin
			rx_state <= RX_IDLE;
			rx_cnt <= '0;
			rx_valid <= 1'b0;
		end
		else if (clk_en)
		begin
			rx_valid <= rx_last && addr_hit;	// single cycle offer
			case (rx_state)
				RX_IDLE: if (!din) rx_state <= RX_PRE;
				RX_PRE:
				begin
					if (din)
					begin
						rx_state <= RX_DATA;	// sync bit seen
						rx_cnt <= CNT_W'(FRAME_BITS - 1);
					end
				end
				default:
				begin
					if (rx_last)
						rx_state <= RX_IDLE;
					else
						rx_cnt <= rx_cnt - 1'b1;
				end
			endcase
		end
	end

	assign rx_addr = rx_sh[FRAME_BITS-1 -: ADDR_WIDTH];
	assign rx_data = rx_sh[DATA_WIDTH-1:0];
	assign rx_broadcast = (rx_addr == BROADCAST_ADDR);

	// a starting preamble or a frame still held by the layer keeps the node up
	assign idle = (tx_state == TX_IDLE) && (rx_state == RX_IDLE) && !tx_valid
		&& din && rx_ready;

	always_ff @(posedge clkin or negedge rst_n)
	begin
		if (!rst_n)
			idle_cnt <= '0;
		else if (bus_rst)
			idle_cnt <= '0;
		else if (clk_en)
		begin
			if (!idle)
				idle_cnt <= '0;
			else if (idle_cnt != SLEEP_THRESHOLD)
				idle_cnt <= idle_cnt + 1'b1;	// saturates at threshold
		end
	end

	assign sleep_req = idle && (idle_cnt == SLEEP_THRESHOLD);

endmodule

/* hw/mbus_node.sv */
`timescale 1ns/1ns

module mbus_node #(
	parameter logic [mbus_pkg::ADDR_WIDTH-1:0] ADDRESS = 8'h3a,
	parameter logic [15:0] SLEEP_THRESHOLD = 16'd1024
) (
	input  logic clkin,
	input  logic rst_n,
	input  logic din,
	output logic dout,
	input  logic req_int,
	input  logic [mbus_pkg::ADDR_WIDTH-1:0] tx_addr,
	input  logic [mbus_pkg::DATA_WIDTH-1:0] tx_data,
	input  logic tx_req,
	output logic tx_ack,
	output logic [mbus_pkg::ADDR_WIDTH-1:0] rx_addr,
	output logic [mbus_pkg::DATA_WIDTH-1:0] rx_data,
	output logic rx_broadcast,
	output logic rx_req,
	output logic rx_fail,
	input  logic rx_ack
);
	import mbus_pkg::*;

	logic bus_clk_en, bus_rst, iso;	// sleep sequencer controls
	logic wake_det, sleep_req;
	logic tx_valid, tx_ready, tx_done;
	logic tx_active, tx_bit;	// controller drive onto the ring
	logic bus_rx_valid, bus_rx_broadcast, rx_ready;
	logic [ADDR_WIDTH-1:0] bus_rx_addr;
	logic [DATA_WIDTH-1:0] bus_rx_data;

	// always-on shell
	mbus_sleep_ctrl sc0 (.*);
	mbus_wire_ctrl wc0 (.*);
	mbus_layer_if lif0 (.*);

	// gated domain
	mbus_bus_ctrl #(
		.ADDRESS(ADDRESS),
		.SLEEP_THRESHOLD(SLEEP_THRESHOLD)
	) bc0 (
		.*,
		.clk_en(bus_clk_en),
		.rx_valid(bus_rx_valid),
		.rx_addr(bus_rx_addr),
		.rx_data(bus_rx_data),
		.rx_broadcast(bus_rx_broadcast)
	);

endmodule

/* tb/tb_mbus_node.sv */
`timescale 1ns/1ns

module tb_mbus_node;
	import mbus_pkg::*;

	localparam logic [ADDR_WIDTH-1:0] ADDRESS = 8'h3a;
	localparam logic [15:0] SLEEP_THRESHOLD = 16'd64;
	localparam int FRAME_LEN = PREAMBLE_LEN + 1 + FRAME_BITS;	// cycles per frame on the ring

	logic clkin, rst_n;
	logic din, dout, req_int;
	logic [ADDR_WIDTH-1:0] tx_addr, rx_addr;
	logic [DATA_WIDTH-1:0] tx_data, rx_data;
	logic tx_req, tx_ack;
	logic rx_broadcast, rx_req, rx_fail, rx_ack;

	int mismatches;
	int timeouts;
	int seed;
	logic [31:0] rnd;

	mbus_node #(
		.ADDRESS(ADDRESS),
		.SLEEP_THRESHOLD(SLEEP_THRESHOLD)
	) dut (
		.clkin(clkin),
		.rst_n(rst_n),
		.din(din),
		.dout(dout),
		.req_int(req_int),
		.tx_addr(tx_addr),
		.tx_data(tx_data),
		.tx_req(tx_req),
		.tx_ack(tx_ack),
		.rx_addr(rx_addr),
		.rx_data(rx_data),
		.rx_broadcast(rx_broadcast),
		.rx_req(rx_req),
		.rx_fail(rx_fail),
		.rx_ack(rx_ack)
	);

	initial
	begin
		clkin = 1'b0;
		forever #5 clkin = ~clkin;
	end

	// all stimulus and sampling happens 1 ns after the rising edge
	task automatic step();
		@(posedge clkin);
		#1;
	endtask

	task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
		if (act !== exp)
		begin
			$display("Error: %s expected %0h actual %0h", name, exp, act);
			mismatches++;
		end
	endtask

	task automatic wait_rx_req(input logic lvl, input int limit, input string name);
		int n;
		n = 0;
		while (rx_req !== lvl && n < limit)
		begin
			step();
			n++;
		end
		if (rx_req !== lvl)
		begin
			$display("%s: rx_req did not go to %0b within %0d cycles", name, lvl, limit);
			timeouts++;
		end
	endtask

	task automatic wait_tx_ack(input logic lvl, input int limit, input string name);
		int n;
		n = 0;
		while (tx_ack !== lvl && n < limit)
		begin
			step();
			n++;
		end
		if (tx_ack !== lvl)
		begin
			$display("%s: tx_ack did not go to %0b within %0d cycles", name, lvl, limit);
			timeouts++;
		end
	endtask

	task automatic wait_rx_fail(input logic lvl, input int limit, input string name);
		int n;
		n = 0;
		while (rx_fail !== lvl && n < limit)
		begin
			step();
			n++;
		end
		if (rx_fail !== lvl)
		begin
			$display("%s: rx_fail did not go to %0b within %0d cycles", name, lvl, limit);
			timeouts++;
		end
	endtask

	// preamble, sync, then address and data msb first; ring left idle high
	task automatic send_frame(input logic [ADDR_WIDTH-1:0] addr,
		input logic [DATA_WIDTH-1:0] data);
		logic [FRAME_BITS-1:0] bits;
		int i;
		bits = {addr, data};
		for (i = 0; i < PREAMBLE_LEN; i++)
		begin
			din = 1'b0;
			step();
		end
		din = 1'b1;	// sync
		step();
		for (i = FRAME_BITS - 1; i >= 0; i--)
		begin
			din = bits[i];
			step();
		end
		din = 1'b1;
	endtask

	task automatic capture_frame(output int pre_len, output logic [FRAME_BITS-1:0] bits);
		int n;
		int i;
		logic found;
		pre_len = 0;
		found = 1'b0;
		n = 0;
		bits = '0;
		while (!found && n < 200)
		begin
			step();
			n++;
			if (dout === 1'b0)
				pre_len++;
			else if (pre_len > 0)
				found = 1'b1;	// first high after the preamble
		end
		if (!found)
		begin
			$display("capture_frame: no preamble and sync bit seen on dout");
			timeouts++;
		end
		else
		begin
			for (i = 0; i < FRAME_BITS; i++)
			begin
				step();
				bits = {bits[FRAME_BITS-2:0], dout};
			end
		end
	endtask

	task automatic ack_rx(input string name);
		rx_ack = 1'b1;
		wait_rx_req(1'b0, 20, name);
		rx_ack = 1'b0;
		step();
	endtask

	// quiet ring and layer long enough for the node to go to sleep
	task automatic settle();
		din = 1'b1;
		req_int = 1'b0;
		tx_req = 1'b0;
		rx_ack = 1'b0;
		repeat (4 * SLEEP_THRESHOLD + 16) step();
	endtask

	// random bits must come back on dout one cycle later
	task automatic forward_stream(input string name);
		int i;
		logic b;
		for (i = 0; i < 64; i++)
		begin
			rnd = $urandom;
			b = rnd[0];
			din = b;
			step();
			check(name, b, dout);
		end
		din = 1'b1;
	endtask

	// a random stream may look like a frame to us, so close any open handshake
	task automatic drain_rx(input string name);
		repeat (FRAME_LEN + 15) step();
		if (rx_req === 1'b1)
			ack_rx(name);
	endtask

	task automatic run_transmit(input string name);
		logic [ADDR_WIDTH-1:0] a;
		logic [DATA_WIDTH-1:0] d;
		logic [FRAME_BITS-1:0] bits;
		int pre_len;
		rnd = $urandom;
		a = rnd[ADDR_WIDTH-1:0];
		d = $urandom;
		tx_addr = a;
		tx_data = d;
		tx_req = 1'b1;
		capture_frame(pre_len, bits);
		check(name, PREAMBLE_LEN, pre_len);
		check(name, a, bits[FRAME_BITS-1 -: ADDR_WIDTH]);
		check(name, d, bits[DATA_WIDTH-1:0]);
		wait_tx_ack(1'b1, 20, name);
		tx_req = 1'b0;
		wait_tx_ack(1'b0, 10, name);
		step();
	endtask

	task automatic test_reset_forwarding();
		check("reset", 1'b0, tx_ack);
		check("reset", 1'b0, rx_req);
		check("reset", 1'b0, rx_fail);
		check("reset", 1'b1, dout);
		check("reset", 1'b1, dut.iso);	// starts out asleep
		forward_stream("forward_after_reset");
		drain_rx("forward_after_reset");
		settle();
		check("forward_asleep", 1'b1, dut.iso);
		forward_stream("forward_asleep");
		drain_rx("forward_asleep");
	endtask

	task automatic test_transmit();
		settle();
		run_transmit("transmit");
	endtask

	task automatic test_unicast();
		logic [DATA_WIDTH-1:0] d;
		logic [ADDR_WIDTH-1:0] other;
		int n;
		int seen;
		settle();
		d = $urandom;
		send_frame(ADDRESS, d);
		wait_rx_req(1'b1, 2 * FRAME_LEN, "unicast");
		check("unicast", ADDRESS, rx_addr);
		check("unicast", d, rx_data);
		check("unicast", 1'b0, rx_broadcast);
		ack_rx("unicast");
		check("unicast", 1'b0, rx_fail);
		// one flipped bit never gives our address or the broadcast one
		settle();
		rnd = $urandom;
		other = ADDRESS ^ (8'h01 << rnd[2:0]);
		send_frame(other, $urandom);
		seen = 0;
		for (n = 0; n < 2 * FRAME_LEN; n++)
		begin
			step();
			if (rx_req === 1'b1)
				seen++;
		end
		check("unicast_other_addr", 0, seen);
	endtask

	task automatic test_broadcast();
		logic [DATA_WIDTH-1:0] d;
		settle();
		d = $urandom;
		send_frame(BROADCAST_ADDR, d);
		wait_rx_req(1'b1, 2 * FRAME_LEN, "broadcast");
		check("broadcast", BROADCAST_ADDR, rx_addr);
		check("broadcast", d, rx_data);
		check("broadcast", 1'b1, rx_broadcast);
		ack_rx("broadcast");
	endtask

	task automatic test_overflow();
		logic [DATA_WIDTH-1:0] d1, d2;
		settle();
		d1 = $urandom;
		d2 = ~d1;
		send_frame(ADDRESS, d1);
		wait_rx_req(1'b1, 2 * FRAME_LEN, "overflow");
		check("overflow", 1'b0, rx_fail);
		send_frame(ADDRESS, d2);	// layer still holds the first one
		wait_rx_fail(1'b1, 20, "overflow");
		check("overflow", 1'b1, rx_req);
		check("overflow", ADDRESS, rx_addr);
		check("overflow", d1, rx_data);
		ack_rx("overflow");
		check("overflow", 1'b0, rx_fail);
		check("overflow", 1'b0, rx_req);
	endtask

	task automatic test_sleep_wake();
		logic [DATA_WIDTH-1:0] d;
		settle();
		check("sleep_wake", 1'b1, dut.iso);
		req_int = 1'b1;
		step();
		step();
		req_int = 1'b0;
		step();
		// interrupt alone releases the controller three cycles later
		check("sleep_wake", 1'b0, dut.iso);
		d = $urandom;
		send_frame(ADDRESS, d);
		wait_rx_req(1'b1, 2 * FRAME_LEN, "sleep_wake");
		check("sleep_wake", ADDRESS, rx_addr);
		check("sleep_wake", d, rx_data);
		check("sleep_wake", 1'b0, rx_broadcast);
		ack_rx("sleep_wake");
		run_transmit("sleep_wake_transmit");
	endtask

	initial
	begin
		mismatches = 0;
		timeouts = 0;
		seed = 75;
		rnd = $urandom(seed);
		rst_n = 1'b0;
		din = 1'b1;
		req_int = 1'b0;
		tx_addr = '0;
		tx_data = '0;
		tx_req = 1'b0;
		rx_ack = 1'b0;
		repeat (2) @(posedge clkin);
		#1;
		rst_n = 1'b1;
		step();

		test_reset_forwarding();
		test_transmit();
		test_unicast();
		test_broadcast();
		test_overflow();
		test_sleep_wake();

		$display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
		if (mismatches == 0 && timeouts == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

/* tb.f */
hw/mbus_pkg.sv
hw/mbus_sleep_ctrl.sv
hw/mbus_wire_ctrl.sv
hw/mbus_layer_if.sv
hw/mbus_bus_ctrl.sv
hw/mbus_node.sv
tb/tb_mbus_node.sv
